/* cpu_core.f */
+incdir+dv
hw/cpu_pkg.sv
hw/store_if.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/execute_unit.sv
hw/cpu_core.sv
dv/cpu_core_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := cpu_core_tb
FILELIST  := cpu_core.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/cpu_tests.svh */
localparam logic [2:0] R_B = 3'd0;
localparam logic [2:0] R_C = 3'd1;
localparam logic [2:0] R_D = 3'd2;
localparam logic [2:0] R_E = 3'd3;
localparam logic [2:0] R_H = 3'd4;
localparam logic [2:0] R_L = 3'd5;
localparam logic [2:0] R_A = 3'd7;
localparam logic [2:0] OP_ADD = 3'd0;
localparam logic [2:0] OP_ADC = 3'd1;
localparam logic [2:0] OP_SUB = 3'd2;
localparam logic [2:0] OP_SBC = 3'd3;
localparam logic [2:0] OP_CP = 3'd7;
localparam logic [1:0] CC_NZ = 2'd0;

int          pc_emit;
logic [15:0] halt_addr;

task automatic emit(input logic [7:0] b);
    mem[pc_emit[15:0]] = b;
    pc_emit++;
endtask

task automatic ld_imm(input logic [2:0] r, input logic [7:0] n);
    emit({2'b00, r, 3'b110});
    emit(n);
endtask

task automatic ld_reg(input logic [2:0] d, input logic [2:0] s);
    emit({2'b01, d, s});
endtask

task automatic store(input logic [2:0] s);
    emit({2'b01, 3'b110, s});   // LD (HL),s
endtask

task automatic alu_reg(input logic [2:0] op, input logic [2:0] s);
    emit({2'b10, op, s});
endtask

task automatic alu_imm(input logic [2:0] op, input logic [7:0] n);
    emit({2'b11, op, 3'b110});
    emit(n);
endtask

task automatic jr(input logic [1:0] cc, input logic [7:0] e);
    emit({3'b001, cc, 3'b000});
    emit(e);
endtask

task automatic begin_program();
    fill_memory();
    pc_emit = 0;
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic run_program();
    halt_addr = pc_emit[15:0];
    emit(8'h76);
    reset_dut();
    wait_halt(halt_addr);
endtask

task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// Returns {carry, zero, result}
function automatic logic [9:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                         input logic [7:0] b, input logic cin);
    int   r;
    logic c;
    case (op)
        3'd0: r = int'(a) + int'(b);
        3'd1: r = int'(a) + int'(b) + int'(cin);
        3'd2, 3'd7: r = int'(a) - int'(b);
        3'd3: r = int'(a) - int'(b) - int'(cin);
        3'd4: r = int'(a & b);
        3'd5: r = int'(a ^ b);
        default: r = int'(a | b);
    endcase
    c = (r > 255) || (r < 0);   // Carry out of add or borrow of subtract
    return {c, r[7:0] == 8'd0, (op == 3'd7) ? a : r[7:0]};
endfunction

function automatic logic jump_taken(input int cc, input logic z, input logic c);
    case (cc)
        0: return !z;
        1: return z;
        2: return !c;
        default: return c;
    endcase
endfunction

task automatic test_load_store();
    logic [7:0] vals [5];
    logic [2:0] dst [5];
    begin_test();
    dst = '{R_B, R_C, R_D, R_E, R_A};
    begin_program();
    for (int i = 0; i < 5; i++)
    begin
        vals[i] = 8'($random(seed));
        ld_imm(dst[i], vals[i]);
    end
    ld_imm(R_H, 8'h80);
    ld_imm(R_L, 8'h10);
    for (int i = 0; i < 5; i++)
    begin
        store(dst[i]);
        expect_write(16'h8010, vals[i]);
    end
    run_program();
    compare_log("load_store");
    check_value(32'(read_log.size() > 0), 32'd1, "reads seen after reset");
    if (read_log.size() > 0)
    begin
        check_value(32'(read_log[0]), 32'h0000, "first read address");
    end
    end_test("load_store");
endtask

task automatic test_alu_ops();
    logic [7:0] pre;
    logic [7:0] a;
    logic [7:0] b;
    logic [9:0] m;
    logic       mc;
    int         n;
    begin_test();
    begin_program();
    mc = 1'b0;
    n = 0;
    ld_imm(R_H, 8'h90);
    for (int op = 0; op < 8; op++)
    begin
        for (int form = 0; form < 2; form++)
        begin
            pre = 8'($random(seed));
            a = 8'($random(seed));
            b = 8'($random(seed));
            ld_imm(R_A, pre);
            alu_reg(OP_ADD, R_A);   // Carry in comes from pre bit 7
            m = alu_model(OP_ADD, pre, pre, mc);
            mc = m[9];
            ld_imm(R_A, a);
            if (form == 0)
            begin
                ld_imm(R_B, b);
                alu_reg(3'(op), R_B);
            end
            else
            begin
                alu_imm(3'(op), b);
            end
            m = alu_model(3'(op), a, b, mc);
            mc = m[9];
            ld_imm(R_L, 8'(n));
            store(R_A);
            expect_write({8'h90, 8'(n)}, m[7:0]);
            n++;
        end
    end
    run_program();
    compare_log("alu_ops");
    end_test("alu_ops");
endtask

task automatic chain16(input logic [2:0] lo_op, input logic [2:0] hi_op,
                       input logic [15:0] x, input logic [15:0] y, input int slot);
    ld_imm(R_A, x[7:0]);
    ld_imm(R_B, y[7:0]);
    alu_reg(lo_op, R_B);
    ld_imm(R_L, 8'(slot));
    store(R_A);
    ld_imm(R_A, x[15:8]);
    ld_imm(R_B, y[15:8]);
    alu_reg(hi_op, R_B);
    ld_imm(R_L, 8'(slot + 1));
    store(R_A);
endtask

task automatic test_carry_chain();
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] sum;
    logic [15:0] diff;
    int          slot;
    begin_test();
    begin_program();
    ld_imm(R_H, 8'ha0);
    slot = 0;
    for (int k = 0; k < 3; k++)
    begin
        x = (k == 0) ? 16'h12ff : ((k == 1) ? 16'h1200 : 16'($random(seed)));
        y = (k == 2) ? 16'($random(seed)) : 16'h0001;
        sum = x + y;
        diff = x - y;
        chain16(OP_ADD, OP_ADC, x, y, slot);
        expect_write({8'ha0, 8'(slot)}, sum[7:0]);
        expect_write({8'ha0, 8'(slot + 1)}, sum[15:8]);
        chain16(OP_SUB, OP_SBC, x, y, slot + 2);
        expect_write({8'ha0, 8'(slot + 2)}, diff[7:0]);
        expect_write({8'ha0, 8'(slot + 3)}, diff[15:8]);
        slot += 4;
    end
    run_program();
    compare_log("carry_chain");
    end_test("carry_chain");
endtask

task automatic test_jumps();
    logic [7:0] a;
    logic [7:0] n;
    int         k;
    int         loop_addr;
    int         e;
    begin_test();
    begin_program();
    ld_imm(R_H, 8'hb0);
    k = 0;
    for (int cc = 0; cc < 4; cc++)
    begin
        for (int eq = 0; eq < 2; eq++)
        begin
            a = 8'($random(seed)) & 8'h7f;
            n = (eq == 1) ? a : a + 8'd1;   // Equal sets Z and below sets C
            ld_imm(R_B, 8'(8'h10 + k));
            ld_imm(R_L, 8'(k));
            ld_imm(R_A, a);
            alu_imm(OP_CP, n);
            jr(2'(cc), 8'h01);              // Skips the marker store
            store(R_B);
            if (!jump_taken(cc, a == n, a < n))
            begin
                expect_write({8'hb0, 8'(k)}, 8'(8'h10 + k));
            end
            k++;
        end
    end
    // Count down from 3
    ld_imm(R_L, 8'h20);
    ld_imm(R_A, 8'd3);
    loop_addr = pc_emit;
    alu_imm(OP_SUB, 8'd1);
    store(R_A);
    e = loop_addr - (pc_emit + 2);
    jr(CC_NZ, 8'(e));
    expect_write(16'hb020, 8'd2);
    expect_write(16'hb020, 8'd1);
    expect_write(16'hb020, 8'd0);
    run_program();
    compare_log("jumps");
    end_test("jumps");
endtask

task automatic test_ordering();
    logic [7:0] b_val;
    logic [7:0] v;
    logic       ordered;
    int         kind;
    begin_test();
    begin_program();
    b_val = 8'h00;
    ld_imm(R_H, 8'hc0);
    for (int i = 0; i < 5 * QUEUE_DEPTH; i++)
    begin
        kind = $unsigned($random(seed)) % 3;
        case (kind)
            0: emit(8'h00);
            1:
            begin
                v = 8'($random(seed));
                ld_imm(R_C, v);
                ld_reg(R_B, R_C);
                b_val = v;
            end
            default:
            begin
                ld_imm(R_L, 8'(i));
                store(R_B);
                expect_write({8'hc0, 8'(i)}, b_val);
            end
        endcase
    end
    ld_imm(R_L, 8'hff);
    store(R_B);
    expect_write(16'hc0ff, b_val);
    run_program();
    compare_log("ordering");
    ordered = 1'b1;
    for (int i = 1; i < read_log.size(); i++)
    begin
        if (read_log[i] < read_log[i-1])
        begin
            ordered = 1'b0;
        end
    end
    check_value(32'(ordered), 32'd1, "read addresses never decrease");
    end_test("ordering");
endtask

/* dv/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb;

    localparam int QUEUE_DEPTH = 4;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 16;      // Bus idle this long after HALT means drained
    localparam int BUDGET_CYCLES = 2000;   // Per-test limit after reset
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (BUDGET_CYCLES + RESET_CYCLES + 8);

    logic        clock;
    logic        rst_n;
    logic [7:0]  db_rdata;
    logic [15:0] db_address;
    logic [7:0]  db_wdata;
    logic        db_nread;
    logic        db_nwrite;

    logic [7:0]  mem [65536];
    logic [15:0] log_addr [$];
    logic [7:0]  log_data [$];
    logic [15:0] read_log [$];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    integer      seed;
    int          errors;
    int          checks;
    int          failed_tests;
    int          test_err_start;
    int          idle_cycles;

    cpu_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) cpu_core_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .db_rdata   (db_rdata),
        .db_address (db_address),
        .db_wdata   (db_wdata),
        .db_nread   (db_nread),
        .db_nwrite  (db_nwrite)
    );

    assign db_rdata = mem[db_address];    // Asynchronous read

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Bus monitor and memory write port
    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            idle_cycles <= 0;
        end
        else
        begin
            if (!db_nwrite)
            begin
                log_addr.push_back(db_address);
                log_data.push_back(db_wdata);
                mem[db_address] = db_wdata;
            end
            if (!db_nread)
            begin
                read_log.push_back(db_address);
            end
            if (!db_nread && !db_nwrite)
            begin
                $display("ERROR at %0t: read and write strobes are low together", $time);
                errors++;
            end
            idle_cycles <= (db_nread && db_nwrite) ? idle_cycles + 1 : 0;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5a);
        end
    endtask

    task automatic reset_dut();
        @(negedge clock);
        rst_n = 1'b0;
        log_addr.delete();
        log_data.delete();
        read_log.delete();
        repeat (RESET_CYCLES)
        begin
            @(negedge clock);
            check_value(32'(db_nread), 32'd1, "db_nread high during reset");
            check_value(32'(db_nwrite), 32'd1, "db_nwrite high during reset");
        end
        rst_n = 1'b1;
        #(CLK_PERIOD / 4);
        check_value(32'(db_nread), 32'd1, "db_nread high in the cycle after reset");
        check_value(32'(db_nwrite), 32'd1, "db_nwrite high in the cycle after reset");
    endtask

    // HALT was the last read and the bus has gone quiet
    task automatic wait_halt(input logic [15:0] addr);
        int cycles;
        cycles = 0;
        while (!(read_log.size() > 0 && read_log[$] == addr && idle_cycles >= DRAIN_CYCLES)
               && cycles < BUDGET_CYCLES)
        begin
            @(negedge clock);
            cycles++;
        end
        if (cycles >= BUDGET_CYCLES)
        begin
            $display("ERROR at %0t: program did not reach HALT and drain within %0d cycles",
                     $time, BUDGET_CYCLES);
            errors++;
        end
    endtask

    task automatic compare_log(input string tag);
        int n;
        n = exp_addr.size();
        check_value(32'(log_addr.size()), 32'(n), {tag, " write count"});
        for (int i = 0; i < n && i < log_addr.size(); i++)
        begin
            check_value(32'(log_addr[i]), 32'(exp_addr[i]),
                        $sformatf("%s write %0d address", tag, i));
            check_value(32'(log_data[i]), 32'(exp_data[i]),
                        $sformatf("%s write %0d data", tag, i));
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors > test_err_start)
        begin
            failed_tests++;
            $display("%s: FAIL (%0d errors)", name, errors - test_err_start);
        end
        else
        begin
            $display("%s: ok", name);
        end
    endtask

    `include "cpu_tests.svh"

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR at %0t: watchdog expired before the tests finished", $time);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        seed = 82;
        errors = 0;
        checks = 0;
        failed_tests = 0;
        test_err_start = 0;
        pc_emit = 0;
        halt_addr = 16'h0000;
        fill_memory();

        test_load_store();
        test_alu_ops();
        test_carry_chain();
        test_jumps();
        test_ordering();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           clock,
    input  logic           rst_n,
    input  cpu_pkg::byte_t db_rdata,
    output cpu_pkg::addr_t db_address,
    output cpu_pkg::byte_t db_wdata,
    output logic           db_nread,
    output logic           db_nwrite
);
    import cpu_pkg::*;

    logic      push;
    logic      full;
    logic      pop;
    logic      empty;
    logic      flush;
    logic      redirect;
    addr_t     redirect_pc;
    inst_pkt_t push_pkt;
    inst_pkt_t pop_pkt;

    store_if store_bus ();

    fetch_unit fetch_unit_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .db_rdata    (db_rdata),
        .db_address  (db_address),
        .db_wdata    (db_wdata),
        .db_nread    (db_nread),
        .db_nwrite   (db_nwrite),
        .push        (push),
        .push_pkt    (push_pkt),
        .full        (full),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .store       (store_bus)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .payload_t   (inst_pkt_t)
    ) inst_queue_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .push     (push),
        .push_pkt (push_pkt),
        .pop      (pop),
        .flush    (flush),
        .full     (full),
        .empty    (empty),
        .pop_pkt  (pop_pkt)
    );

    execute_unit execute_unit_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .empty       (empty),
        .pop_pkt     (pop_pkt),
        .pop         (pop),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .store       (store_bus)
    );

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               empty,
    input  cpu_pkg::inst_pkt_t pop_pkt,
    output logic               pop,
    output logic               flush,
    output logic               redirect,
    output cpu_pkg::addr_t     redirect_pc,
    store_if.exec              store
);
    import cpu_pkg::*;

    opc_fields_t f;
    alu_op_t     op;
    logic        valid;
    logic        is_ld_imm;
    logic        is_ld_reg;
    logic        is_store;
    logic        is_alu;
    logic        is_alu_imm;
    logic        is_jr;
    byte_t       rd1;
    byte_t       rd2;
    addr_t       hl;
    byte_t       alu_b;
    byte_t       alu_res;
    logic        alu_zero;
    logic        alu_carry;
    reg_idx_t    wr_sel;
    byte_t       wr_data;
    logic        wr_en;
    logic        flag_z;
    logic        flag_c;
    logic        cond_met;

    assign valid = !empty;
    assign f = opc_fields_t'(pop_pkt.opcode);
    assign op = alu_op_t'(f.dst);

    // HALT and anything not matched here retire as a NOP
    assign is_ld_imm = f.grp == GRP_MISC && f.src == REG_MEM && f.dst != REG_MEM;
    assign is_jr = f.grp == GRP_MISC && f.dst[2] && f.src == 3'b000;
    assign is_ld_reg = f.grp == GRP_LD && f.dst != REG_MEM && f.src != REG_MEM;
    assign is_store = f.grp == GRP_LD && f.dst == REG_MEM && f.src != REG_MEM;
    assign is_alu_imm = f.grp == GRP_IMM && f.src == REG_MEM;
    assign is_alu = (f.grp == GRP_ALU && f.src != REG_MEM) || is_alu_imm;

    reg_file reg_file_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .rd1_sel (REG_A),
        .rd2_sel (f.src),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rd1     (rd1),
        .rd2     (rd2),
        .hl      (hl)
    );

    assign alu_b = is_alu_imm ? pop_pkt.imm : rd2;

    alu alu_inst (
        .a        (rd1),
        .b        (alu_b),
        .op       (op),
        .carry_in (flag_c),
        .result   (alu_res),
        .zero     (alu_zero),
        .carry    (alu_carry)
    );

    assign wr_sel = is_alu ? REG_A : f.dst;
    assign wr_data = is_ld_imm ? pop_pkt.imm : (is_ld_reg ? rd2 : alu_res);
    assign wr_en = valid && (is_ld_imm || is_ld_reg || (is_alu && op != ALU_CP));

    always_comb
    begin
        case (jr_cond_t'(f.dst[1:0]))
            JR_NZ:   cond_met = !flag_z;
            JR_Z:    cond_met = flag_z;
            JR_NC:   cond_met = !flag_c;
            default: cond_met = flag_c;
        endcase
    end

    // Target is relative to the byte after JR
    assign redirect = valid && is_jr && cond_met;
    assign flush = redirect;
    assign redirect_pc = pop_pkt.next_pc + {{8{pop_pkt.imm[7]}}, pop_pkt.imm};

    assign store.store_req = valid && is_store;
    assign store.store_addr = hl;
    assign store.store_data = rd2;

    assign pop = valid && (!is_store || store.store_done);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (valid && is_alu)
        begin
            flag_z <= alu_zero;
            flag_c <= alu_carry;
        end
    end

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
    parameter int  QUEUE_DEPTH = 4,
    parameter type payload_t   = logic [31:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_pkt,
    input  logic     pop,
    input  logic     flush,
    output logic     full,
    output logic     empty,
    output payload_t pop_pkt
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    payload_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_push;
    logic do_pop;

    assign full = count == (PTR_W+1)'(QUEUE_DEPTH);
    assign empty = count == '0;
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign pop_pkt = mem[rd_ptr];

    // Pointers wrap on their own because depth is a power of two
    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_pkt;
        end
    end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::byte_t     db_rdata,
    output cpu_pkg::addr_t     db_address,
    output cpu_pkg::byte_t     db_wdata,
    output logic               db_nread,
    output logic               db_nwrite,
    output logic               push,
    output cpu_pkg::inst_pkt_t push_pkt,
    input  logic               full,
    input  logic               redirect,
    input  cpu_pkg::addr_t     redirect_pc,
    store_if.bus               store
);
    import cpu_pkg::*;

    addr_t pc;
    byte_t op_byte;     // Opcode waiting for its immediate
    logic  have_op;
    logic  halted;
    logic  active;      // Keeps the bus idle in the cycle after reset
    logic  wr_cycle;
    logic  rd_en;
    logic  last_byte;

    // LD r,n and ALU A,n and JR cc,e carry an immediate byte
    function automatic logic has_imm(byte_t op);
        opc_fields_t f;
        f = opc_fields_t'(op);
        return (f.grp == GRP_MISC && f.src == REG_MEM && f.dst != REG_MEM)
            || (f.grp == GRP_IMM && f.src == REG_MEM)
            || (f.grp == GRP_MISC && f.dst[2] && f.src == 3'b000);
    endfunction

    // A store owns the bus from request to done
    assign rd_en = active && !halted && !redirect && !store.store_req && !wr_cycle
                   && (have_op || !full);

    assign last_byte = have_op || !has_imm(db_rdata);
    assign push = rd_en && last_byte;
    assign push_pkt = '{
        opcode:  have_op ? op_byte : db_rdata,
        imm:     have_op ? db_rdata : 8'h00,
        next_pc: pc + addr_t'(1)
    };

    assign db_address = wr_cycle ? store.store_addr : pc;
    assign db_wdata = store.store_data;
    assign db_nread = !rd_en;
    assign db_nwrite = !wr_cycle;
    assign store.store_done = wr_cycle;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc <= RESET_PC;
            have_op <= 1'b0;
            halted <= 1'b0;
            active <= 1'b0;
            wr_cycle <= 1'b0;
        end
        else
        begin
            active <= 1'b1;
            wr_cycle <= store.store_req && !wr_cycle;
            if (redirect)
            begin
                pc <= redirect_pc;  // Partial instruction is dropped
                have_op <= 1'b0;
                halted <= 1'b0;
            end
            else if (rd_en)
            begin
                pc <= pc + addr_t'(1);
                have_op <= !last_byte;
                if (push && push_pkt.opcode == OPC_HALT)
                begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (rd_en && !have_op)
        begin
            op_byte <= db_rdata;
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd1_sel,
    input  cpu_pkg::reg_idx_t rd2_sel,
    input  cpu_pkg::reg_idx_t wr_sel,
    input  cpu_pkg::byte_t    wr_data,
    input  logic              wr_en,
    output cpu_pkg::byte_t    rd1,
    output cpu_pkg::byte_t    rd2,
    output cpu_pkg::addr_t    hl
);
    import cpu_pkg::*;

    byte_t regs [8];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_sel != REG_MEM)    // Slot 6 is memory, not a register
        begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rd1 = regs[rd1_sel];
    assign rd2 = regs[rd2_sel];
    assign hl = {regs[REG_H], regs[REG_L]};

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic             carry_in,
    output cpu_pkg::byte_t   result,
    output logic             zero,
    output logic             carry
);
    import cpu_pkg::*;

    logic [8:0] wide;   // Bit 8 holds carry or borrow

    always_comb
    begin
        case (op)
            ALU_ADD:
                wide = {1'b0, a} + {1'b0, b};
            ALU_ADC:
                wide = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
            ALU_SUB, ALU_CP:
                wide = {1'b0, a} - {1'b0, b};
            ALU_SBC:
                wide = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
            ALU_AND:
                wide = {1'b0, a & b};
            ALU_XOR:
                wide = {1'b0, a ^ b};
            default:
                wide = {1'b0, a | b};
        endcase
    end

    // Compare leaves A alone
    assign result = (op == ALU_CP) ? a : wide[7:0];
    assign zero = wide[7:0] == 8'd0;
    assign carry = wide[8];

endmodule

/* hw/store_if.sv */
`timescale 1ns/1ps

interface store_if;
    import cpu_pkg::*;

    logic  store_req;   // Held until store_done
    addr_t store_addr;
    byte_t store_data;
    logic  store_done;

    // Execute side requests the write
    modport exec (
        output store_req,
        output store_addr,
        output store_data,
        input  store_done
    );

    // Bus owner performs it
    modport bus (
        input  store_req,
        input  store_addr,
        input  store_data,
        output store_done
    );

endinterface

/* hw/cpu_pkg.sv */
package cpu_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [2:0] reg_idx_t;

    // Register code 6 selects memory at H:L
    localparam reg_idx_t REG_H = 3'd4;
    localparam reg_idx_t REG_L = 3'd5;
    localparam reg_idx_t REG_MEM = 3'd6;
    localparam reg_idx_t REG_A = 3'd7;

    // Opcode bits 5:3 in ALU instructions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        JR_NZ = 2'd0,
        JR_Z  = 2'd1,
        JR_NC = 2'd2,
        JR_C  = 2'd3
    } jr_cond_t;

    typedef enum logic [1:0] {
        GRP_MISC = 2'b00,
        GRP_LD   = 2'b01,
        GRP_ALU  = 2'b10,
        GRP_IMM  = 2'b11
    } opc_grp_t;

    // xx ddd sss
    typedef struct packed {
        opc_grp_t grp;
        reg_idx_t dst;
        reg_idx_t src;
    } opc_fields_t;

    typedef struct packed {
        byte_t opcode;
        byte_t imm;
        addr_t next_pc;     // Address after the instruction
    } inst_pkt_t;

    localparam byte_t OPC_NOP = 8'h00;
    localparam byte_t OPC_HALT = 8'h76;
    localparam addr_t RESET_PC = 16'h0000;

endpackage
